//--- flist.f
source/issue_cfg_pkg.sv
source/issue_ctrl_pkg.sv
source/issue_dup_filter.sv
source/issue_slot.sv
source/issue_stage.sv
test/issue_stage_props.sv
test/tb_issue_stage.sv

//--- test/tb_issue_stage.sv
/*
 * issue stage testbench
 * directed and random stimulus for the dual-lane issue stage,
 * checking is done by the bound assertions
 */
module tb_issue_stage;
    timeunit 1ns;
    timeprecision 100ps;
    import issue_cfg_pkg::*;
    import issue_ctrl_pkg::*;

    localparam int MAX_CYCLES  = 1000;
    localparam int RAND_CYCLES = 300;
    localparam int LANE_W      = INST_DATA_W + 3 * REG_ADDR_W + DECINFO_W + COMMIT_ID_W + 3;

    logic                   clk;
    logic                   rst_n;
    logic [ISSUE_LANES-1:0] issue_req_i;
    logic [CU_BUS_W-1:0]    stall_flag_i;

    logic [INST_ADDR_W-1:0] inst1_addr_i, inst2_addr_i;
    logic [INST_DATA_W-1:0] inst1_i, inst2_i;
    logic                   inst1_reg_we_i, inst2_reg_we_i;
    logic [REG_ADDR_W-1:0]  inst1_reg_waddr_i, inst2_reg_waddr_i;
    logic [REG_ADDR_W-1:0]  inst1_reg1_raddr_i, inst2_reg1_raddr_i;
    logic [REG_ADDR_W-1:0]  inst1_reg2_raddr_i, inst2_reg2_raddr_i;
    logic [DECINFO_W-1:0]   inst1_dec_info_i, inst2_dec_info_i;
    logic                   inst1_is_pred_branch_i, inst2_is_pred_branch_i;
    logic [COMMIT_ID_W-1:0] inst1_commit_id_i, inst2_commit_id_i;
    logic                   inst1_illegal_inst_i, inst2_illegal_inst_i;

    logic [INST_ADDR_W-1:0] inst1_addr_o, inst2_addr_o;
    logic [INST_DATA_W-1:0] inst1_o, inst2_o;
    logic                   inst1_reg_we_o, inst2_reg_we_o;
    logic [REG_ADDR_W-1:0]  inst1_reg_waddr_o, inst2_reg_waddr_o;
    logic [REG_ADDR_W-1:0]  inst1_reg1_raddr_o, inst2_reg1_raddr_o;
    logic [REG_ADDR_W-1:0]  inst1_reg2_raddr_o, inst2_reg2_raddr_o;
    logic [DECINFO_W-1:0]   inst1_dec_info_o, inst2_dec_info_o;
    logic                   inst1_is_pred_branch_o, inst2_is_pred_branch_o;
    logic [COMMIT_ID_W-1:0] inst1_commit_id_o, inst2_commit_id_o;
    logic                   inst1_illegal_inst_o, inst2_illegal_inst_o;
    logic                   inst1_valid_o, inst2_valid_o;

    issue_stage dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // unrelated control bits get random values
    task automatic set_ctrl(input logic stall, input logic flush);
        logic [CU_BUS_W-1:0] bus;
        bus = CU_BUS_W'($urandom);
        bus[CU_STALL_DISPATCH] = stall;
        bus[CU_FLUSH] = flush;
        stall_flag_i = bus;
    endtask

    task automatic set_lane(input int lane, input logic [INST_ADDR_W-1:0] addr);
        logic [127:0] r;
        r = {$urandom, $urandom, $urandom, $urandom};
        if (lane == 1) begin
            inst1_addr_i = addr;
            {inst1_i, inst1_reg_we_i, inst1_reg_waddr_i, inst1_reg1_raddr_i,
             inst1_reg2_raddr_i, inst1_dec_info_i, inst1_is_pred_branch_i,
             inst1_commit_id_i, inst1_illegal_inst_i} = r[LANE_W-1:0];
        end else begin
            inst2_addr_i = addr;
            {inst2_i, inst2_reg_we_i, inst2_reg_waddr_i, inst2_reg1_raddr_i,
             inst2_reg2_raddr_i, inst2_dec_info_i, inst2_is_pred_branch_i,
             inst2_commit_id_i, inst2_illegal_inst_i} = r[LANE_W-1:0];
        end
    endtask

    // small address set so that repeats are common
    function automatic logic [INST_ADDR_W-1:0] pick_addr();
        logic [1:0] sel;
        sel = 2'($urandom);
        if (sel == 2'd0) begin
            return '0;
        end
        return INST_ADDR_W'(32'h100 + 32'(sel) * 32'd4);
    endfunction

    task automatic report_check_failure();
        $display("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h",
                 dut0.u_props.fail_time, dut0.u_props.fail_sig,
                 dut0.u_props.fail_exp, dut0.u_props.fail_act);
    endtask

    task automatic wait_valid(input int lane, input int max_cycles);
        int n;
        n = 0;
        while (((lane == 1) ? inst1_valid_o : inst2_valid_o) !== 1'b1 && n < max_cycles) begin
            next_cycle();
            n++;
        end
        if (((lane == 1) ? inst1_valid_o : inst2_valid_o) !== 1'b1) begin
            $display("timeout: lane %0d never showed a valid instruction", lane);
            $display("Done: errors found");
            $fatal(1, "wait for lane valid timed out");
        end
    endtask

    // stops at the first failing assertion or when the run overruns
    initial begin
        int cycles;
        cycles = 0;
        while (dut0.u_props.fail_cnt == 0 && cycles < MAX_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (dut0.u_props.fail_cnt != 0) begin
            report_check_failure();
        end else begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
        end
        $display("Done: errors found");
        $fatal(1, "run stopped");
    end

    initial begin
        logic [31:0] r;
        void'($urandom(5));
        rst_n = 1'b0;
        issue_req_i = '0;
        stall_flag_i = '0;
        set_lane(1, '0);
        set_lane(2, '0);
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // idle cycles, nothing requested
        next_cycle();
        next_cycle();

        // plain issue on both lanes
        set_lane(1, 'h200);
        set_lane(2, 'h204);
        issue_req_i = 2'b11;
        next_cycle();
        issue_req_i = 2'b00;
        wait_valid(1, 4);
        wait_valid(2, 4);

        // same address twice on lane 1, the second is dropped
        set_lane(1, 'h300);
        issue_req_i = 2'b01;
        next_cycle();
        set_lane(1, 'h300);
        next_cycle();
        set_lane(1, 'h304);
        next_cycle();
        issue_req_i = 2'b00;
        next_cycle();

        // stall over a few edges with new inputs presented
        set_lane(1, 'h400);
        set_lane(2, 'h404);
        issue_req_i = 2'b11;
        next_cycle();
        set_ctrl(1'b1, 1'b0);
        set_lane(1, 'h408);
        set_lane(2, 'h40c);
        repeat (3) next_cycle();
        set_ctrl(1'b0, 1'b0);
        next_cycle();

        // flush, then the flushed address comes back
        set_ctrl(1'b0, 1'b1);
        next_cycle();
        set_ctrl(1'b0, 1'b0);
        next_cycle();

        // flush on top of stall
        set_ctrl(1'b1, 1'b1);
        next_cycle();
        set_ctrl(1'b0, 1'b0);
        issue_req_i = 2'b00;
        next_cycle();

        for (int i = 0; i < RAND_CYCLES; i++) begin
            r = $urandom;
            set_lane(1, pick_addr());
            set_lane(2, pick_addr());
            issue_req_i = ISSUE_LANES'(r);
            set_ctrl(r[4:2] == 3'd0, r[8:5] == 4'd0);
            next_cycle();
        end
        issue_req_i = '0;
        set_ctrl(1'b0, 1'b0);
        next_cycle();
        next_cycle();

        if (dut0.u_props.fail_cnt == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            report_check_failure();
            $display("Done: errors found");
            $fatal(1, "checks failed");
        end
    end

endmodule

//--- test/issue_stage_props.sv
/*
 * issue stage checks
 * concurrent assertions for the issue, stall, flush, duplicate and
 * output masking rules of the issue stage
 */
module issue_stage_props #(
    parameter int INST_ADDR_W = issue_cfg_pkg::INST_ADDR_W,
    parameter int INST_DATA_W = issue_cfg_pkg::INST_DATA_W,
    parameter int REG_ADDR_W  = issue_cfg_pkg::REG_ADDR_W,
    parameter int DECINFO_W   = issue_cfg_pkg::DECINFO_W,
    parameter int COMMIT_ID_W = issue_cfg_pkg::COMMIT_ID_W,
    parameter int PAY_W       = INST_ADDR_W + INST_DATA_W + 3 * REG_ADDR_W
                              + DECINFO_W + COMMIT_ID_W + 3
) (
    input logic                                   clk,
    input logic                                   rst_n,
    input logic [issue_ctrl_pkg::CU_BUS_W-1:0]    ctrl_i,
    input logic [issue_ctrl_pkg::ISSUE_LANES-1:0] req_i,
    input logic [PAY_W-1:0]                       in_pay1_i,
    input logic [PAY_W-1:0]                       in_pay2_i,
    input logic [PAY_W-1:0]                       pay1_i,
    input logic [PAY_W-1:0]                       pay2_i,
    input logic [issue_ctrl_pkg::ISSUE_LANES-1:0] valid_i
);
    timeunit 1ns;
    timeprecision 100ps;
    import issue_ctrl_pkg::*;

    logic                   flush;
    logic                   stall;
    logic [PAY_W-1:0]       in_pay [ISSUE_LANES];
    logic [PAY_W-1:0]       pay    [ISSUE_LANES];
    logic [ISSUE_LANES-1:0] dup;
    logic [2*PAY_W+1:0]     outs;

    // reference state one cycle behind the inputs
    logic [INST_ADDR_W-1:0] hist_addr [ISSUE_LANES];
    logic [ISSUE_LANES-1:0] hist_req;
    logic [PAY_W-1:0]       in_pay_q  [ISSUE_LANES];
    logic [ISSUE_LANES-1:0] exp_valid_q;
    logic [2*PAY_W+1:0]     outs_q;
    logic                   acc_q;
    logic                   hold_q;
    logic                   flush_q;

    // details of the first failure for the testbench
    int                     fail_cnt = 0;
    time                    fail_time;
    string                  fail_sig;
    logic [255:0]           fail_exp;
    logic [255:0]           fail_act;

    assign flush     = ctrl_i[CU_FLUSH];
    assign stall     = ctrl_i[CU_STALL_DISPATCH];
    assign in_pay[0] = in_pay1_i;
    assign in_pay[1] = in_pay2_i;
    assign pay[0]    = pay1_i;
    assign pay[1]    = pay2_i;
    assign outs      = {valid_i, pay1_i, pay2_i};

    // repeat of a nonzero address that was requested on the last accepted cycle
    always_comb begin
        for (int k = 0; k < ISSUE_LANES; k++) begin
            dup[k] = hist_req[k]
                   && (in_pay[k][PAY_W-1 -: INST_ADDR_W] == hist_addr[k])
                   && (in_pay[k][PAY_W-1 -: INST_ADDR_W] != '0);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < ISSUE_LANES; k++) begin
                hist_addr[k] <= '0;
                in_pay_q[k]  <= '0;
            end
            hist_req    <= '0;
            exp_valid_q <= '0;
            outs_q      <= '0;
            acc_q       <= 1'b0;
            hold_q      <= 1'b0;
            flush_q     <= 1'b0;
        end else begin
            acc_q   <= !stall && !flush;
            hold_q  <= stall && !flush;
            flush_q <= flush;
            outs_q  <= outs;
            for (int k = 0; k < ISSUE_LANES; k++) begin
                in_pay_q[k]    <= in_pay[k];
                exp_valid_q[k] <= req_i[k] && !dup[k];
                if (flush) begin
                    hist_addr[k] <= '0;
                    hist_req[k]  <= 1'b0;
                end else if (!stall) begin
                    hist_addr[k] <= in_pay[k][PAY_W-1 -: INST_ADDR_W];
                    hist_req[k]  <= req_i[k];
                end
            end
        end
    end

    function automatic void note_fail(input string sig, input logic [255:0] exp_v,
                                      input logic [255:0] act_v);
        if (fail_cnt == 0) begin
            fail_time = $time;
            fail_sig  = sig;
            fail_exp  = exp_v;
            fail_act  = act_v;
        end
        fail_cnt++;
    endfunction

    // stall holds every output across the edge
    hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        (hold_q && !flush) |-> (outs == outs_q))
    else begin
        note_fail("all lane outputs", $sampled(outs_q), $sampled(outs));
        $error("outputs changed under dispatch stall");
    end

    flush_now_a: assert property (@(posedge clk) disable iff (!rst_n)
        flush |-> (outs == '0))
    else begin
        note_fail("all lane outputs", '0, $sampled(outs));
        $error("outputs not zero while flush is high");
    end

    flush_after_a: assert property (@(posedge clk) disable iff (!rst_n)
        flush_q |-> (valid_i == '0))
    else begin
        note_fail("inst1_valid_o/inst2_valid_o", '0, $sampled(valid_i));
        $error("valid set in the cycle after a flush");
    end

    for (genvar k = 0; k < ISSUE_LANES; k++) begin : g_lane
        // request minus duplicates decides valid
        valid_a: assert property (@(posedge clk) disable iff (!rst_n)
            (acc_q && !flush) |-> (valid_i[k] == exp_valid_q[k]))
        else begin
            note_fail(k == 0 ? "inst1_valid_o" : "inst2_valid_o",
                      $sampled(exp_valid_q[k]), $sampled(valid_i[k]));
            $error("lane valid does not follow request and duplicate rule");
        end

        data_a: assert property (@(posedge clk) disable iff (!rst_n)
            (acc_q && !flush && exp_valid_q[k]) |-> (pay[k] == in_pay_q[k]))
        else begin
            note_fail(k == 0 ? "inst1 payload" : "inst2 payload",
                      $sampled(in_pay_q[k]), $sampled(pay[k]));
            $error("issued fields differ from the captured instruction");
        end

        mask_a: assert property (@(posedge clk) disable iff (!rst_n)
            !valid_i[k] |-> (pay[k] == '0))
        else begin
            note_fail(k == 0 ? "inst1 payload" : "inst2 payload", '0, $sampled(pay[k]));
            $error("payload not zero on an invalid lane");
        end
    end

endmodule

bind issue_stage issue_stage_props #(
    .INST_ADDR_W (INST_ADDR_W),
    .INST_DATA_W (INST_DATA_W),
    .REG_ADDR_W  (REG_ADDR_W),
    .DECINFO_W   (DECINFO_W),
    .COMMIT_ID_W (COMMIT_ID_W)
) u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl_i    (stall_flag_i),
    .req_i     (issue_req_i),
    .in_pay1_i ({inst1_addr_i, inst1_i, inst1_reg_we_i, inst1_reg_waddr_i,
                 inst1_reg1_raddr_i, inst1_reg2_raddr_i, inst1_dec_info_i,
                 inst1_is_pred_branch_i, inst1_commit_id_i, inst1_illegal_inst_i}),
    .in_pay2_i ({inst2_addr_i, inst2_i, inst2_reg_we_i, inst2_reg_waddr_i,
                 inst2_reg1_raddr_i, inst2_reg2_raddr_i, inst2_dec_info_i,
                 inst2_is_pred_branch_i, inst2_commit_id_i, inst2_illegal_inst_i}),
    .pay1_i    ({inst1_addr_o, inst1_o, inst1_reg_we_o, inst1_reg_waddr_o,
                 inst1_reg1_raddr_o, inst1_reg2_raddr_o, inst1_dec_info_o,
                 inst1_is_pred_branch_o, inst1_commit_id_o, inst1_illegal_inst_o}),
    .pay2_i    ({inst2_addr_o, inst2_o, inst2_reg_we_o, inst2_reg_waddr_o,
                 inst2_reg1_raddr_o, inst2_reg2_raddr_o, inst2_dec_info_o,
                 inst2_is_pred_branch_o, inst2_commit_id_o, inst2_illegal_inst_o}),
    .valid_i   ({inst2_valid_o, inst1_valid_o})
);

//--- source/issue_stage.sv
/*
 * dual-lane issue stage
 * filters duplicate issue requests and registers two decoded
 * instructions per cycle under dispatch stall and pipeline flush
 */
module issue_stage #(
    parameter int INST_ADDR_W = issue_cfg_pkg::INST_ADDR_W,
    parameter int INST_DATA_W = issue_cfg_pkg::INST_DATA_W,
    parameter int REG_ADDR_W  = issue_cfg_pkg::REG_ADDR_W,
    parameter int DECINFO_W   = issue_cfg_pkg::DECINFO_W,
    parameter int COMMIT_ID_W = issue_cfg_pkg::COMMIT_ID_W
) (
    input  logic                                   clk,
    input  logic                                   rst_n,

    // lane 1 from decode
    input  logic [INST_ADDR_W-1:0]                 inst1_addr_i,
    input  logic [INST_DATA_W-1:0]                 inst1_i,
    input  logic                                   inst1_reg_we_i,
    input  logic [REG_ADDR_W-1:0]                  inst1_reg_waddr_i,
    input  logic [REG_ADDR_W-1:0]                  inst1_reg1_raddr_i,
    input  logic [REG_ADDR_W-1:0]                  inst1_reg2_raddr_i,
    input  logic [DECINFO_W-1:0]                   inst1_dec_info_i,
    input  logic                                   inst1_is_pred_branch_i,
    input  logic [COMMIT_ID_W-1:0]                 inst1_commit_id_i,
    input  logic                                   inst1_illegal_inst_i,

    // lane 2 from decode
    input  logic [INST_ADDR_W-1:0]                 inst2_addr_i,
    input  logic [INST_DATA_W-1:0]                 inst2_i,
    input  logic                                   inst2_reg_we_i,
    input  logic [REG_ADDR_W-1:0]                  inst2_reg_waddr_i,
    input  logic [REG_ADDR_W-1:0]                  inst2_reg1_raddr_i,
    input  logic [REG_ADDR_W-1:0]                  inst2_reg2_raddr_i,
    input  logic [DECINFO_W-1:0]                   inst2_dec_info_i,
    input  logic                                   inst2_is_pred_branch_i,
    input  logic [COMMIT_ID_W-1:0]                 inst2_commit_id_i,
    input  logic                                   inst2_illegal_inst_i,

    // bit 0 requests lane 1, bit 1 lane 2
    input  logic [issue_ctrl_pkg::ISSUE_LANES-1:0] issue_req_i,
    input  logic [issue_ctrl_pkg::CU_BUS_W-1:0]    stall_flag_i,

    // lane 1 to execute
    output logic [INST_ADDR_W-1:0]                 inst1_addr_o,
    output logic [INST_DATA_W-1:0]                 inst1_o,
    output logic                                   inst1_reg_we_o,
    output logic [REG_ADDR_W-1:0]                  inst1_reg_waddr_o,
    output logic [REG_ADDR_W-1:0]                  inst1_reg1_raddr_o,
    output logic [REG_ADDR_W-1:0]                  inst1_reg2_raddr_o,
    output logic [DECINFO_W-1:0]                   inst1_dec_info_o,
    output logic                                   inst1_is_pred_branch_o,
    output logic [COMMIT_ID_W-1:0]                 inst1_commit_id_o,
    output logic                                   inst1_illegal_inst_o,
    output logic                                   inst1_valid_o,

    // lane 2 to execute
    output logic [INST_ADDR_W-1:0]                 inst2_addr_o,
    output logic [INST_DATA_W-1:0]                 inst2_o,
    output logic                                   inst2_reg_we_o,
    output logic [REG_ADDR_W-1:0]                  inst2_reg_waddr_o,
    output logic [REG_ADDR_W-1:0]                  inst2_reg1_raddr_o,
    output logic [REG_ADDR_W-1:0]                  inst2_reg2_raddr_o,
    output logic [DECINFO_W-1:0]                   inst2_dec_info_o,
    output logic                                   inst2_is_pred_branch_o,
    output logic [COMMIT_ID_W-1:0]                 inst2_commit_id_o,
    output logic                                   inst2_illegal_inst_o,
    output logic                                   inst2_valid_o
);
    import issue_ctrl_pkg::*;

    logic                   flush;
    logic                   stall;
    logic [ISSUE_LANES-1:0] issue_ok;

    // control bus decode, done once for the whole stage
    assign flush = stall_flag_i[CU_FLUSH];
    assign stall = stall_flag_i[CU_STALL_DISPATCH];

    issue_dup_filter #(
        .INST_ADDR_W (INST_ADDR_W)
    ) u_filter (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (flush),
        .stall_i      (stall),
        .issue_req_i  (issue_req_i),
        .inst1_addr_i (inst1_addr_i),
        .inst2_addr_i (inst2_addr_i),
        .issue_ok_o   (issue_ok)
    );

    issue_slot #(
        .INST_ADDR_W (INST_ADDR_W),
        .INST_DATA_W (INST_DATA_W),
        .REG_ADDR_W  (REG_ADDR_W),
        .DECINFO_W   (DECINFO_W),
        .COMMIT_ID_W (COMMIT_ID_W)
    ) u_slot1 (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush_i          (flush),
        .stall_i          (stall),
        .issue_ok_i       (issue_ok[0]),
        .addr_i           (inst1_addr_i),
        .inst_i           (inst1_i),
        .reg_we_i         (inst1_reg_we_i),
        .reg_waddr_i      (inst1_reg_waddr_i),
        .reg1_raddr_i     (inst1_reg1_raddr_i),
        .reg2_raddr_i     (inst1_reg2_raddr_i),
        .dec_info_i       (inst1_dec_info_i),
        .is_pred_branch_i (inst1_is_pred_branch_i),
        .commit_id_i      (inst1_commit_id_i),
        .illegal_inst_i   (inst1_illegal_inst_i),
        .addr_o           (inst1_addr_o),
        .inst_o           (inst1_o),
        .reg_we_o         (inst1_reg_we_o),
        .reg_waddr_o      (inst1_reg_waddr_o),
        .reg1_raddr_o     (inst1_reg1_raddr_o),
        .reg2_raddr_o     (inst1_reg2_raddr_o),
        .dec_info_o       (inst1_dec_info_o),
        .is_pred_branch_o (inst1_is_pred_branch_o),
        .commit_id_o      (inst1_commit_id_o),
        .illegal_inst_o   (inst1_illegal_inst_o),
        .valid_o          (inst1_valid_o)
    );

    issue_slot #(
        .INST_ADDR_W (INST_ADDR_W),
        .INST_DATA_W (INST_DATA_W),
        .REG_ADDR_W  (REG_ADDR_W),
        .DECINFO_W   (DECINFO_W),
        .COMMIT_ID_W (COMMIT_ID_W)
    ) u_slot2 (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush_i          (flush),
        .stall_i          (stall),
        .issue_ok_i       (issue_ok[1]),
        .addr_i           (inst2_addr_i),
        .inst_i           (inst2_i),
        .reg_we_i         (inst2_reg_we_i),
        .reg_waddr_i      (inst2_reg_waddr_i),
        .reg1_raddr_i     (inst2_reg1_raddr_i),
        .reg2_raddr_i     (inst2_reg2_raddr_i),
        .dec_info_i       (inst2_dec_info_i),
        .is_pred_branch_i (inst2_is_pred_branch_i),
        .commit_id_i      (inst2_commit_id_i),
        .illegal_inst_i   (inst2_illegal_inst_i),
        .addr_o           (inst2_addr_o),
        .inst_o           (inst2_o),
        .reg_we_o         (inst2_reg_we_o),
        .reg_waddr_o      (inst2_reg_waddr_o),
        .reg1_raddr_o     (inst2_reg1_raddr_o),
        .reg2_raddr_o     (inst2_reg2_raddr_o),
        .dec_info_o       (inst2_dec_info_o),
        .is_pred_branch_o (inst2_is_pred_branch_o),
        .commit_id_o      (inst2_commit_id_o),
        .illegal_inst_o   (inst2_illegal_inst_o),
        .valid_o          (inst2_valid_o)
    );

endmodule

//--- source/issue_slot.sv
/*
 * issue slot
 * issue register of one lane with stall hold, flush clear and
 * zero masking of the outputs when the lane is not valid
 */
module issue_slot #(
    parameter int INST_ADDR_W = issue_cfg_pkg::INST_ADDR_W,
    parameter int INST_DATA_W = issue_cfg_pkg::INST_DATA_W,
    parameter int REG_ADDR_W  = issue_cfg_pkg::REG_ADDR_W,
    parameter int DECINFO_W   = issue_cfg_pkg::DECINFO_W,
    parameter int COMMIT_ID_W = issue_cfg_pkg::COMMIT_ID_W
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush_i,
    input  logic                   stall_i,
    input  logic                   issue_ok_i,

    // decoded lane fields
    input  logic [INST_ADDR_W-1:0] addr_i,
    input  logic [INST_DATA_W-1:0] inst_i,
    input  logic                   reg_we_i,
    input  logic [REG_ADDR_W-1:0]  reg_waddr_i,
    input  logic [REG_ADDR_W-1:0]  reg1_raddr_i,
    input  logic [REG_ADDR_W-1:0]  reg2_raddr_i,
    input  logic [DECINFO_W-1:0]   dec_info_i,
    input  logic                   is_pred_branch_i,
    input  logic [COMMIT_ID_W-1:0] commit_id_i,
    input  logic                   illegal_inst_i,

    // issued lane fields
    output logic [INST_ADDR_W-1:0] addr_o,
    output logic [INST_DATA_W-1:0] inst_o,
    output logic                   reg_we_o,
    output logic [REG_ADDR_W-1:0]  reg_waddr_o,
    output logic [REG_ADDR_W-1:0]  reg1_raddr_o,
    output logic [REG_ADDR_W-1:0]  reg2_raddr_o,
    output logic [DECINFO_W-1:0]   dec_info_o,
    output logic                   is_pred_branch_o,
    output logic [COMMIT_ID_W-1:0] commit_id_o,
    output logic                   illegal_inst_o,
    output logic                   valid_o
);

    logic                   valid_q;
    logic [INST_ADDR_W-1:0] addr_q;
    logic [INST_DATA_W-1:0] inst_q;
    logic                   reg_we_q;
    logic [REG_ADDR_W-1:0]  reg_waddr_q;
    logic [REG_ADDR_W-1:0]  reg1_raddr_q;
    logic [REG_ADDR_W-1:0]  reg2_raddr_q;
    logic [DECINFO_W-1:0]   dec_info_q;
    logic                   is_pred_branch_q;
    logic [COMMIT_ID_W-1:0] commit_id_q;
    logic                   illegal_inst_q;

    logic                   out_en;

    // valid flag, flush wins over stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= issue_ok_i;
        end
    end

    // payload, captured together with the issue decision
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q           <= '0;
            inst_q           <= '0;
            reg_we_q         <= 1'b0;
            reg_waddr_q      <= '0;
            reg1_raddr_q     <= '0;
            reg2_raddr_q     <= '0;
            dec_info_q       <= '0;
            is_pred_branch_q <= 1'b0;
            commit_id_q      <= '0;
            illegal_inst_q   <= 1'b0;
        end else if (!stall_i) begin
            addr_q           <= addr_i;
            inst_q           <= inst_i;
            reg_we_q         <= reg_we_i;
            reg_waddr_q      <= reg_waddr_i;
            reg1_raddr_q     <= reg1_raddr_i;
            reg2_raddr_q     <= reg2_raddr_i;
            dec_info_q       <= dec_info_i;
            is_pred_branch_q <= is_pred_branch_i;
            commit_id_q      <= commit_id_i;
            illegal_inst_q   <= illegal_inst_i;
        end
    end

    // a flush kills the lane in the same cycle
    assign out_en = valid_q & ~flush_i;

    assign valid_o          = out_en;
    assign addr_o           = out_en ? addr_q       : '0;
    assign inst_o           = out_en ? inst_q       : '0;
    assign reg_we_o         = out_en & reg_we_q;
    assign reg_waddr_o      = out_en ? reg_waddr_q  : '0;
    assign reg1_raddr_o     = out_en ? reg1_raddr_q : '0;
    assign reg2_raddr_o     = out_en ? reg2_raddr_q : '0;
    assign dec_info_o       = out_en ? dec_info_q   : '0;
    assign is_pred_branch_o = out_en & is_pred_branch_q;
    assign commit_id_o      = out_en ? commit_id_q  : '0;
    assign illegal_inst_o   = out_en & illegal_inst_q;

endmodule

//--- source/issue_dup_filter.sv
/*
 * issue request filter
 * keeps per-lane issue history and drops requests for an instruction
 * that was already requested on the previous accepted cycle
 */
module issue_dup_filter #(
    parameter int INST_ADDR_W = issue_cfg_pkg::INST_ADDR_W
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   flush_i,
    input  logic                                   stall_i,
    input  logic [issue_ctrl_pkg::ISSUE_LANES-1:0] issue_req_i,
    input  logic [INST_ADDR_W-1:0]                 inst1_addr_i,
    input  logic [INST_ADDR_W-1:0]                 inst2_addr_i,
    output logic [issue_ctrl_pkg::ISSUE_LANES-1:0] issue_ok_o
);
    import issue_ctrl_pkg::*;

    // current lane addresses, indexed like the request vector
    logic [INST_ADDR_W-1:0] cur_addr  [ISSUE_LANES];

    // history of the last accepted cycle
    logic [INST_ADDR_W-1:0] prev_addr [ISSUE_LANES];
    logic [ISSUE_LANES-1:0] prev_req;

    logic [ISSUE_LANES-1:0] dup;

    // lane 1 sits on bit 0 of the request vector
    assign cur_addr[0] = inst1_addr_i;
    assign cur_addr[1] = inst2_addr_i;

    // same nonzero address as last time and it was requested then
    always_comb begin
        for (int i = 0; i < ISSUE_LANES; i++) begin
            dup[i] = prev_req[i]
                   && (cur_addr[i] == prev_addr[i])
                   && (cur_addr[i] != '0);
        end
    end

    // history update
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ISSUE_LANES; i++) begin
                prev_addr[i] <= '0;
            end
            prev_req <= '0;
        end else if (flush_i) begin
            // flushed instructions may legally come back
            for (int i = 0; i < ISSUE_LANES; i++) begin
                prev_addr[i] <= '0;
            end
            prev_req <= '0;
        end else if (!stall_i) begin
            for (int i = 0; i < ISSUE_LANES; i++) begin
                prev_addr[i] <= cur_addr[i];
            end
            // raw request, not issue_ok, so a repeated address stays blocked
            prev_req <= issue_req_i;
        end
    end

    // stall and flush are applied in the slots
    assign issue_ok_o = issue_req_i & ~dup;

endmodule

//--- source/issue_ctrl_pkg.sv
/*
 * pipeline control bus layout
 * bit positions of the stall and flush controls and the issue lane count
 */
package issue_ctrl_pkg;

    // control bus width from the pipeline control unit
    localparam int CU_BUS_W = 8;

    // flush of the whole pipeline
    localparam int CU_FLUSH = 7;

    // stall of the dispatch/issue stage only
    // the remaining bits serve other stages
    localparam int CU_STALL_DISPATCH = 3;

    // lanes issued per cycle
    localparam int ISSUE_LANES = 2;

endpackage

//--- source/issue_cfg_pkg.sv
/*
 * issue stage field widths
 * default widths of the instruction and decode fields carried per lane
 */
package issue_cfg_pkg;

    // instruction address, one 32-bit word
    localparam int INST_ADDR_W = 32;

    // raw instruction word
    localparam int INST_DATA_W = 32;

    // architectural register index
    localparam int REG_ADDR_W = 5;

    // decode information bus from the decoder
    localparam int DECINFO_W = 41;

    // commit id, sized to the number of in-flight entries
    localparam int COMMIT_ID_W = 3;

endpackage
